//--- logic/cache_pkg.sv
package cache_pkg;

	localparam int data_w         = 32;
	localparam int word_off_w     = 2;
	localparam int words_per_line = 1 << word_off_w;
	localparam int index_w        = 4;
	localparam int num_sets       = 1 << index_w;
	localparam int tag_w          = 10;

	typedef logic [data_w-1:0] data_t;

	// word address without byte offset
	typedef struct packed {
		logic [tag_w-1:0]      tag;
		logic [index_w-1:0]    index;
		logic [word_off_w-1:0] word_off;
	} cache_addr_t;

	typedef struct packed {
		logic [tag_w-1:0]   tag;
		logic [index_w-1:0] index;
	} line_addr_t;

	typedef data_t [words_per_line-1:0] data_line_t;
	typedef data_line_t [1:0] set_data_t;	// indexed by way

	typedef struct packed {
		logic             valid;
		logic             dirty;
		logic [tag_w-1:0] tag;
	} way_flags_t;

	// lru = 1 means way 0 was used last, way 1 goes next
	typedef struct packed {
		way_flags_t [1:0] way;
		logic             lru;
	} set_flags_t;

	typedef enum logic {
		op_rd,
		op_wr
	} req_op_t;

	typedef struct packed {
		req_op_t     op;
		cache_addr_t addr;
		data_t       data;
	} cache_req_t;

	typedef enum logic [2:0] {
		st_idle,
		st_check,
		st_done,
		st_evict,
		st_load,
		st_load2
	} cache_state_t;

	typedef enum logic [1:0] {
		mg_none,
		mg_hit,
		mg_fill
	} merge_sel_t;

endpackage

//--- logic/cache_array.sv
`timescale 1ns/100ps

module cache_array
	import cache_pkg::*;
(
	input  logic               clk_50m,
	input  logic               rst_n,
	input  logic               en,
	input  logic [index_w-1:0] index,
	input  logic               wr_data,
	input  logic               wr_flags,
	input  set_data_t          data_in,
	input  set_flags_t         flags_in,
	output set_data_t          rd_data,
	output set_flags_t         rd_flags
);

	set_data_t  data_mem [num_sets];
	set_flags_t flag_mem [num_sets];

	// read returns the old set when written in the same cycle
	always_ff @(posedge clk_50m) begin
		if (en) begin
			if (wr_data)
				data_mem[index] <= data_in;
			rd_data <= data_mem[index];
		end
	end

	always_ff @(posedge clk_50m, negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < num_sets; i++)
				flag_mem[i] <= '0;
			rd_flags <= '0;
		end else if (en) begin
			if (wr_flags)
				flag_mem[index] <= flags_in;
			rd_flags <= flag_mem[index];	// held while en is low
		end
	end

	// a write only happens on an enabled cycle
	wr_needs_en: assert property (
		@(posedge clk_50m) disable iff (!rst_n)
		(wr_data || wr_flags) |-> en
	) else $error("cache_array write without en");

endmodule

//--- logic/tag_check.sv
`timescale 1ns/100ps

module tag_check
	import cache_pkg::*;
(
	input  set_flags_t       flags,
	input  logic [tag_w-1:0] tag,
	output logic             hit,
	output logic             hit_way,
	output logic             victim_way,
	output logic             victim_dirty
);

	logic [1:0] way_hit;

	always_comb begin
		for (int w = 0; w < 2; w++)
			way_hit[w] = flags.way[w].valid && (flags.way[w].tag == tag);
	end

	assign hit     = |way_hit;
	assign hit_way = way_hit[1];	// way 0 unless way 1 matched

	// lru points away from the way used last
	assign victim_way   = flags.lru;
	assign victim_dirty = flags.way[victim_way].valid && flags.way[victim_way].dirty;

	// a fill never installs a tag that is already present in the set
	always_comb begin
		assert (!(way_hit[0] && way_hit[1]))
		else $error("tag_check both ways hit for tag %h", tag);
	end

endmodule

//--- logic/line_merge.sv
`timescale 1ns/100ps

module line_merge
	import cache_pkg::*;
(
	input  merge_sel_t sel,
	input  cache_req_t req,
	input  logic       hit_way,
	input  logic       victim_way,
	input  set_data_t  cur_data,
	input  set_flags_t cur_flags,
	input  set_data_t  arr_data,
	input  set_flags_t arr_flags,
	input  data_line_t fill_line,
	output set_data_t  data_out,
	output set_flags_t flags_out,
	output data_t      rd_word,
	output data_line_t victim_line
);

	logic [word_off_w-1:0] word_off;
	logic [tag_w-1:0]      req_tag;

	assign word_off = req.addr.word_off;
	assign req_tag  = req.addr.tag;

	always_comb begin
		data_out  = cur_data;
		flags_out = cur_flags;

		unique case (sel)
			mg_hit: begin
				// live array output holds the set after check or load2
				data_out  = arr_data;
				flags_out = arr_flags;
				if (req.op == op_wr) begin
					data_out[hit_way][word_off]   = req.data;
					flags_out.way[hit_way].valid = 1'b1;
					flags_out.way[hit_way].dirty = 1'b1;
					flags_out.way[hit_way].tag   = req_tag;
				end
				flags_out.lru = ~hit_way;
			end

			mg_fill: begin
				data_out[victim_way]            = fill_line;
				flags_out.way[victim_way].valid = 1'b1;
				flags_out.way[victim_way].dirty = 1'b0;	// clean after fill
				flags_out.way[victim_way].tag   = req_tag;
				// lru only moves on the hit update
			end

			default: begin
				data_out  = cur_data;
				flags_out = cur_flags;
			end
		endcase
	end

	assign rd_word     = arr_data[hit_way][word_off];
	assign victim_line = cur_data[victim_way];

endmodule

//--- logic/cache_ctrl.sv
`timescale 1ns/100ps

module cache_ctrl
	import cache_pkg::*;
(
	input  logic         clk_50m,
	input  logic         rst_n,
	input  logic         valid,
	input  req_op_t      op,
	input  logic         hit,
	input  logic         victim_dirty,
	input  logic         mem_done,
	output logic         en,
	output logic         wr_data,
	output logic         wr_flags,
	output logic         load_set,
	output logic         clr_set,
	output merge_sel_t   sel,
	output logic         mem_req,
	output logic         mem_wr,
	output logic         done,
	output cache_state_t state
);

	cache_state_t next_state;
	logic         mem_ack_q;	// memory answered last cycle
	logic         mem_fin;

	always_ff @(posedge clk_50m, negedge rst_n) begin
		if (!rst_n) begin
			state     <= st_idle;
			mem_ack_q <= 1'b0;
		end else begin
			state     <= next_state;
			mem_ack_q <= mem_fin;
		end
	end

	// one idle cycle on the memory port between write-back and fill
	assign mem_req = ((state == st_evict) || (state == st_load)) && !mem_ack_q;
	assign mem_wr  = mem_req && (state == st_evict);
	assign mem_fin = mem_req && mem_done;
	assign done    = (state == st_done);

	always_comb begin
		next_state = state;
		en         = 1'b0;
		wr_data    = 1'b0;
		wr_flags   = 1'b0;
		load_set   = 1'b0;
		clr_set    = 1'b0;
		sel        = mg_none;

		unique case (state)
			st_idle: begin
				if (valid) begin
					en         = 1'b1;	// set read lands in check
					next_state = st_check;
				end else begin
					clr_set = 1'b1;
				end
			end

			st_check: begin
				load_set = 1'b1;
				if (hit)
					next_state = st_done;
				else if (victim_dirty)
					next_state = st_evict;
				else
					next_state = st_load;
			end

			st_evict: begin
				if (mem_fin)
					next_state = st_load;
			end

			st_load: begin
				if (mem_fin) begin
					en         = 1'b1;
					wr_data    = 1'b1;
					wr_flags   = 1'b1;
					sel        = mg_fill;
					next_state = st_load2;
				end
			end

			st_load2: begin
				en         = 1'b1;	// reread the filled set
				next_state = st_done;
			end

			st_done: begin
				en         = 1'b1;
				wr_data    = (op == op_wr);
				wr_flags   = 1'b1;	// lru on every access
				sel        = mg_hit;
				next_state = st_idle;
			end

			default: next_state = st_idle;
		endcase
	end

	// the fill path must leave the requested line resident
	done_is_hit: assert property (
		@(posedge clk_50m) disable iff (!rst_n)
		(state == st_done) |-> hit
	) else $error("cache_ctrl reached st_done without a hit");

	mem_req_held: assert property (
		@(posedge clk_50m) disable iff (!rst_n)
		(mem_req && !mem_done) |=> mem_req
	) else $error("cache_ctrl dropped mem_req before mem_done");

endmodule

//--- logic/mem_sys.sv
`timescale 1ns/100ps

module mem_sys
	import cache_pkg::*;
(
	input  logic       clk_50m,
	input  logic       rst_n,
	input  logic       valid,
	input  cache_req_t req,
	output data_t      rd_data,
	output logic       done,
	output logic       mem_req,
	output logic       mem_wr,
	output line_addr_t mem_addr,
	output data_line_t mem_wr_line,
	input  data_line_t mem_rd_line,
	input  logic       mem_done
);

	cache_addr_t  addr;
	cache_state_t state;
	merge_sel_t   sel;
	logic         en, wr_data, wr_flags, load_set, clr_set;
	logic         hit, hit_way, victim_way, victim_dirty;
	set_data_t    arr_data, cur_data, new_data;
	set_flags_t   arr_flags, cur_flags, new_flags;

	assign addr = req.addr;

	always_ff @(posedge clk_50m, negedge rst_n) begin
		if (!rst_n)
			cur_flags <= '0;
		else if (clr_set)
			cur_flags <= '0;
		else if (load_set)
			cur_flags <= arr_flags;
	end

	always_ff @(posedge clk_50m) begin
		if (clr_set)
			cur_data <= '0;
		else if (load_set)
			cur_data <= arr_data;
	end

	// write-back goes to the victim's own line
	always_comb begin
		mem_addr.index = addr.index;
		if (state == st_evict)
			mem_addr.tag = cur_flags.way[victim_way].tag;
		else
			mem_addr.tag = addr.tag;
	end

	cache_ctrl cache_ctrl_inst (
		.clk_50m(clk_50m), .rst_n(rst_n), .valid(valid), .op(req.op),
		.hit(hit), .victim_dirty(victim_dirty), .mem_done(mem_done),
		.en(en), .wr_data(wr_data), .wr_flags(wr_flags),
		.load_set(load_set), .clr_set(clr_set), .sel(sel),
		.mem_req(mem_req), .mem_wr(mem_wr), .done(done), .state(state)
	);

	cache_array cache_array_inst (
		.clk_50m(clk_50m), .rst_n(rst_n), .en(en), .index(addr.index),
		.wr_data(wr_data), .wr_flags(wr_flags),
		.data_in(new_data), .flags_in(new_flags),
		.rd_data(arr_data), .rd_flags(arr_flags)
	);

	tag_check tag_check_inst (
		.flags(arr_flags), .tag(addr.tag), .hit(hit), .hit_way(hit_way),
		.victim_way(victim_way), .victim_dirty(victim_dirty)
	);

	line_merge line_merge_inst (
		.sel(sel), .req(req), .hit_way(hit_way), .victim_way(victim_way),
		.cur_data(cur_data), .cur_flags(cur_flags),
		.arr_data(arr_data), .arr_flags(arr_flags), .fill_line(mem_rd_line),
		.data_out(new_data), .flags_out(new_flags),
		.rd_word(rd_data), .victim_line(mem_wr_line)
	);

endmodule

//--- verification/clk_gen.sv
`timescale 1ns/100ps

module clk_gen (
	output logic clk_50m,
	output logic rst_n
);

	initial begin
		clk_50m = 1'b0;
		forever #10 clk_50m = ~clk_50m;	// 20 ns period
	end

	// low over the first two rising edges
	initial begin
		rst_n = 1'b0;
		repeat (2) @(posedge clk_50m);
		#1 rst_n = 1'b1;
	end

endmodule

//--- verification/mem_sys_tb.sv
`timescale 1ns/100ps

module mem_sys_tb
	import cache_pkg::*;
();

	typedef struct packed {
		req_op_t               op;
		logic [tag_w-1:0]      tag;
		logic [index_w-1:0]    index;
		logic [word_off_w-1:0] off;
		data_t                 data;
		logic                  hit;	// expect no memory traffic
		logic                  wb;
		logic [tag_w-1:0]      wb_tag;	// victim line on the write-back
	} step_t;

	step_t steps [13] = '{
		'{op_rd, 10'd1, 4'd3, 2'd0, 32'h0,         1'b0, 1'b0, 10'd0},	// cold read
		'{op_wr, 10'd1, 4'd3, 2'd1, 32'h1111_aaaa, 1'b1, 1'b0, 10'd0},
		'{op_rd, 10'd1, 4'd3, 2'd1, 32'h0,         1'b1, 1'b0, 10'd0},
		'{op_wr, 10'd2, 4'd3, 2'd2, 32'h2222_bbbb, 1'b0, 1'b0, 10'd0},
		'{op_rd, 10'd1, 4'd3, 2'd1, 32'h0,         1'b1, 1'b0, 10'd0},	// B is now lru
		'{op_wr, 10'd3, 4'd3, 2'd3, 32'h3333_cccc, 1'b0, 1'b1, 10'd2},	// C evicts dirty B
		'{op_rd, 10'd1, 4'd3, 2'd1, 32'h0,         1'b1, 1'b0, 10'd0},
		'{op_rd, 10'd2, 4'd3, 2'd2, 32'h0,         1'b0, 1'b1, 10'd3},
		'{op_wr, 10'd5, 4'd9, 2'd3, 32'h5555_dddd, 1'b0, 1'b0, 10'd0},
		'{op_wr, 10'd6, 4'd9, 2'd2, 32'h6666_eeee, 1'b0, 1'b0, 10'd0},
		'{op_wr, 10'd7, 4'd9, 2'd0, 32'h7777_ffff, 1'b0, 1'b1, 10'd5},
		'{op_rd, 10'd5, 4'd9, 2'd3, 32'h0,         1'b0, 1'b1, 10'd6},
		'{op_rd, 10'd0, 4'd0, 2'd2, 32'h0,         1'b0, 1'b0, 10'd0}
	};

	logic       clk_50m;
	logic       rst_n;
	logic       valid;
	cache_req_t req;
	data_t      rd_data;
	logic       done;
	logic       mem_req;
	logic       mem_wr;
	line_addr_t mem_addr;
	data_line_t mem_wr_line;
	data_line_t mem_rd_line;
	logic       mem_done;

	data_t      backing [1 << $bits(cache_addr_t)];	// memory behind the cache
	data_t      shadow  [1 << $bits(cache_addr_t)];	// what the processor should see
	integer     seed = 32'hf5f9_b542;
	int         n_rd = 0;
	int         n_wr = 0;
	int         wb_rd_mark;	// fills seen when the last write-back landed
	line_addr_t wb_addr;
	data_line_t wb_line;
	line_addr_t fill_addr;

	clk_gen clk_gen_inst (.clk_50m(clk_50m), .rst_n(rst_n));

	mem_sys mem_sys_inst (
		.clk_50m(clk_50m), .rst_n(rst_n), .valid(valid), .req(req),
		.rd_data(rd_data), .done(done), .mem_req(mem_req), .mem_wr(mem_wr),
		.mem_addr(mem_addr), .mem_wr_line(mem_wr_line),
		.mem_rd_line(mem_rd_line), .mem_done(mem_done)
	);

	function automatic data_t pattern(input logic [$bits(cache_addr_t)-1:0] a);
		return 32'h6b00_0000 + data_t'(a);
	endfunction

	function automatic cache_addr_t step_addr(input step_t s);
		cache_addr_t a;
		a.tag      = s.tag;
		a.index    = s.index;
		a.word_off = s.off;
		return a;
	endfunction

	task automatic fail_now(input string msg);
		$display("ERROR %0t: %s", $time, msg);
		$display("Some tests failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_data(input string what, input data_t got, input data_t exp);
		if (got !== exp)
			fail_now($sformatf("%s got %h expected %h", what, got, exp));
	endtask

	task automatic check_line_addr(input string what, input line_addr_t got,
		input line_addr_t exp);
		if (got !== exp)
			fail_now($sformatf("%s got tag %h index %h expected tag %h index %h",
				what, got.tag, got.index, exp.tag, exp.index));
	endtask

	task automatic check_flag(input string what, input logic got, input logic exp);
		if (got !== exp)
			fail_now($sformatf("%s got %b expected %b", what, got, exp));
	endtask

	// holds one request until done
	// cycles counts from the accepting cycle
	task automatic do_access(input req_op_t op, input cache_addr_t a, input data_t d,
		output data_t got, output int cycles, output logic saw_mem);
		logic seen;
		@(posedge clk_50m);
		#1;
		valid    = 1'b1;
		req.op   = op;
		req.addr = a;
		req.data = d;
		cycles   = -1;
		saw_mem  = 1'b0;
		seen     = 1'b0;
		while (!seen) begin
			@(negedge clk_50m);
			cycles++;
			if (mem_req)
				saw_mem = 1'b1;
			seen = done;
			if (cycles > 300)
				fail_now($sformatf("timed out waiting for done on address %h", a));
		end
		got = rd_data;
		@(posedge clk_50m);
		#1;
		valid = 1'b0;
	endtask

	// memory model answering each request after 0 to 5 cycles
	initial begin
		cache_addr_t a;
		int          lat;
		logic        pending;
		mem_done    = 1'b0;
		mem_rd_line = '0;
		pending     = 1'b0;
		lat         = 0;
		for (int i = 0; i < (1 << $bits(cache_addr_t)); i++)
			backing[i] = pattern(i[$bits(cache_addr_t)-1:0]);
		forever begin
			@(posedge clk_50m);
			#1;
			if (mem_done) begin
				mem_done = 1'b0;
			end else if (mem_req) begin
				if (!pending) begin
					pending = 1'b1;
					lat     = $unsigned($random(seed)) % 6;
				end
				if (lat == 0) begin
					for (int w = 0; w < words_per_line; w++) begin
						a.tag      = mem_addr.tag;
						a.index    = mem_addr.index;
						a.word_off = word_off_w'(w);
						if (mem_wr)
							backing[a] = mem_wr_line[w];
						else
							mem_rd_line[w] = backing[a];
					end
					if (mem_wr) begin
						wb_addr    = mem_addr;
						wb_line    = mem_wr_line;
						wb_rd_mark = n_rd;
						n_wr++;
					end else begin
						fill_addr = mem_addr;
						n_rd++;
					end
					pending  = 1'b0;
					mem_done = 1'b1;
				end else begin
					lat--;
				end
			end
		end
	end

	initial begin
		cache_addr_t a;
		cache_addr_t wa;
		line_addr_t  exp_line;
		data_t       got;
		int          cycles;
		logic        saw_mem;
		int          rd0;
		int          wr0;
		int          n;
		valid = 1'b0;
		req   = '0;
		for (int i = 0; i < (1 << $bits(cache_addr_t)); i++)
			shadow[i] = pattern(i[$bits(cache_addr_t)-1:0]);

		n = 0;
		do begin
			@(negedge clk_50m);
			n++;
			if (n > 10)
				fail_now("reset was never released");
		end while (!rst_n);
		check_flag("done after reset", done, 1'b0);
		check_flag("mem_req after reset", mem_req, 1'b0);

		foreach (steps[i]) begin
			a   = step_addr(steps[i]);
			rd0 = n_rd;
			wr0 = n_wr;
			do_access(steps[i].op, a, steps[i].data, got, cycles, saw_mem);
			if (steps[i].op == op_rd)
				check_data($sformatf("step %0d read of %h", i, a), got, shadow[a]);
			if (steps[i].hit) begin
				check_flag($sformatf("step %0d mem_req on a hit", i), saw_mem, 1'b0);
				if (cycles != 2)
					fail_now($sformatf("step %0d hit took %0d cycles", i, cycles));
			end else begin
				if (n_rd != rd0 + 1)
					fail_now($sformatf("step %0d miss made %0d fills", i, n_rd - rd0));
				exp_line.tag   = steps[i].tag;
				exp_line.index = steps[i].index;
				check_line_addr($sformatf("step %0d fill", i), fill_addr, exp_line);
			end
			if (steps[i].wb) begin
				if (n_wr != wr0 + 1 || wb_rd_mark != rd0)
					fail_now($sformatf("step %0d write-back missing or after fill", i));
				exp_line.tag   = steps[i].wb_tag;
				exp_line.index = steps[i].index;
				check_line_addr($sformatf("step %0d write-back", i), wb_addr, exp_line);
				for (int w = 0; w < words_per_line; w++) begin
					wa.tag      = wb_addr.tag;
					wa.index    = wb_addr.index;
					wa.word_off = word_off_w'(w);
					check_data($sformatf("step %0d write-back word %0d", i, w),
						wb_line[w], shadow[wa]);
				end
			end else if (n_wr != wr0) begin
				fail_now($sformatf("step %0d made an unexpected write-back", i));
			end
			if (steps[i].op == op_wr)
				shadow[a] = steps[i].data;
		end

		// every table address again with misses and write-backs allowed
		foreach (steps[i]) begin
			a = step_addr(steps[i]);
			do_access(op_rd, a, '0, got, cycles, saw_mem);
			check_data($sformatf("final read of %h", a), got, shadow[a]);
		end

		$display("All tests passed");
		$finish;
	end

endmodule

//--- src.f
logic/cache_pkg.sv
logic/cache_array.sv
logic/tag_check.sv
logic/line_merge.sv
logic/cache_ctrl.sv
logic/mem_sys.sv
verification/clk_gen.sv
verification/mem_sys_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the cache testbench with Verilator and run it.
# The exit status is the simulator's, so a $fatal in the testbench fails the script.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module mem_sys_tb \
	-f src.f \
	-o sim_mem_sys
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "verilator build failed with status $build_status"
	exit $build_status
fi

if [ ! -x ./obj_dir/sim_mem_sys ]; then
	echo "simulation binary was not produced"
	exit 1
fi

./obj_dir/sim_mem_sys
sim_status=$?
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit $sim_status
fi

exit 0
